//--- src/core_settings.svh
/*
 * core settings
 * widths fixed by the RV32 integer ISA
 */
`default_nettype none

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path width
`define XLEN 32

// architectural registers x0..x31
`define REG_COUNT 32
`define REG_IDX_W 5 // log2 of REG_COUNT

`endif

`default_nettype wire

//--- src/core_pkg.sv
/*
 * core types
 * opcode, alu function and operand select encodings
 */
`default_nettype none

package core_pkg;

	////////////////////////////////////////////////////////////////////
	// major opcodes, only the ones this core decodes
	////////////////////////////////////////////////////////////////////
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011 // wfi lives here
	} opcode_t;

	////////////////////////////////////////////////////////////////////
	// alu operations
	////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0, // also the no-op default
		ALU_SUB    = 4'h1,
		ALU_SLT    = 4'h2,
		ALU_SLTU   = 4'h3,
		ALU_AND    = 4'h4,
		ALU_OR     = 4'h5,
		ALU_XOR    = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha, // low half
		ALU_MULH   = 4'hb, // signed x signed, high half
		ALU_MULHSU = 4'hc, // signed x unsigned
		ALU_MULHU  = 4'hd  // unsigned x unsigned
	} alu_func_t;

	// operand a source
	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_PC   = 2'h1, // auipc
		OPA_IS_ZERO = 2'h2  // lui
	} opa_select_t;

	// operand b source, imm already shaped as I or U by the decoder
	typedef enum logic {
		OPB_IS_RS2 = 1'b0,
		OPB_IS_IMM = 1'b1
	} opb_select_t;

endpackage

`default_nettype wire

//--- src/id_ex_if.sv
/*
 * decode to execute bundle
 * decoded controls plus source indices and values
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

interface id_ex_if import core_pkg::*; ();
	logic                  valid;
	alu_func_t             alu_func;
	opa_select_t           opa_select;
	opb_select_t           opb_select;
	logic [`XLEN-1:0]      pc;
	logic [`XLEN-1:0]      imm;       // I or U immediate
	logic [`REG_IDX_W-1:0] rs1_idx;   // kept for forwarding compare
	logic [`REG_IDX_W-1:0] rs2_idx;
	logic [`XLEN-1:0]      rs1_value;
	logic [`XLEN-1:0]      rs2_value;
	logic [`REG_IDX_W-1:0] rd;
	logic                  reg_write; // rd != 0 already folded in
	logic                  illegal;
	logic                  halt;

	modport id (output valid, alu_func, opa_select, opb_select, pc, imm,
		rs1_idx, rs2_idx, rs1_value, rs2_value, rd, reg_write, illegal, halt);

	modport ex (input valid, alu_func, opa_select, opb_select, pc, imm,
		rs1_idx, rs2_idx, rs1_value, rs2_value, rd, reg_write, illegal, halt);
endinterface

`default_nettype wire

//--- src/ex_wb_if.sv
/*
 * execute to result bundle
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

interface ex_wb_if ();
	logic                  valid;
	logic [`REG_IDX_W-1:0] rd;
	logic                  reg_write;
	logic [`XLEN-1:0]      value;   // alu or mul result
	logic                  illegal;
	logic                  halt;

	// ex also reads these back for forwarding
	modport ex (output valid, rd, reg_write, value, illegal, halt);

	modport wb (input valid, rd, reg_write, value, illegal, halt);
endinterface

`default_nettype wire

//--- src/decoder.sv
/*
 * instruction decoder
 * rv32 word to alu controls and immediate, purely combinational
 * flags illegal words and wfi
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

module decoder import core_pkg::*; (
	input  logic [`XLEN-1:0] inst,
	input  logic             valid_in,   // low means no-op out
	output alu_func_t        alu_func,
	output opa_select_t      opa_select,
	output opb_select_t      opb_select,
	output logic [`XLEN-1:0] imm,
	output logic             reg_write,
	output logic             illegal,
	output logic             halt
);

	opcode_t               opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [`REG_IDX_W-1:0] rd;
	logic                  writes_rd;   // before the x0 check

	assign opcode = opcode_t'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];

	assign reg_write = writes_rd & (rd != '0);

	always_comb begin
		// defaults equal a no-op
		alu_func   = ALU_ADD;
		opa_select = OPA_IS_RS1;
		opb_select = OPB_IS_RS2;
		imm        = '0;
		writes_rd  = 1'b0;
		illegal    = 1'b0;
		halt       = 1'b0;
		if (valid_in) begin
			case (opcode)
				OPC_LUI: begin
					writes_rd  = 1'b1;
					opa_select = OPA_IS_ZERO;
					opb_select = OPB_IS_IMM;
					imm        = {inst[31:12], 12'b0};
				end
				OPC_AUIPC: begin
					writes_rd  = 1'b1;
					opa_select = OPA_IS_PC;
					opb_select = OPB_IS_IMM;
					imm        = {inst[31:12], 12'b0};
				end
				OPC_OP_IMM: begin
					writes_rd  = 1'b1;
					opb_select = OPB_IS_IMM;
					imm        = {{(`XLEN-12){inst[31]}}, inst[31:20]}; // sign extended I
					casez ({funct7, funct3})
						10'b???????_000: alu_func = ALU_ADD;
						10'b???????_010: alu_func = ALU_SLT;
						10'b???????_011: alu_func = ALU_SLTU;
						10'b???????_100: alu_func = ALU_XOR;
						10'b???????_110: alu_func = ALU_OR;
						10'b???????_111: alu_func = ALU_AND;
						10'b0000000_001: alu_func = ALU_SLL;
						10'b0000000_101: alu_func = ALU_SRL;
						10'b0100000_101: alu_func = ALU_SRA;
						default: begin
							writes_rd = 1'b0; // bad shift encoding
							illegal   = 1'b1;
						end
					endcase
					// shifts only take shamt
					if (funct3 == 3'b001 || funct3 == 3'b101)
						imm = {{(`XLEN-5){1'b0}}, inst[24:20]};
				end
				OPC_OP: begin
					writes_rd = 1'b1;
					case ({funct7, funct3})
						10'b0000000_000: alu_func = ALU_ADD;
						10'b0100000_000: alu_func = ALU_SUB;
						10'b0000000_001: alu_func = ALU_SLL;
						10'b0000000_010: alu_func = ALU_SLT;
						10'b0000000_011: alu_func = ALU_SLTU;
						10'b0000000_100: alu_func = ALU_XOR;
						10'b0000000_101: alu_func = ALU_SRL;
						10'b0100000_101: alu_func = ALU_SRA;
						10'b0000000_110: alu_func = ALU_OR;
						10'b0000000_111: alu_func = ALU_AND;
						10'b0000001_000: alu_func = ALU_MUL;
						10'b0000001_001: alu_func = ALU_MULH;
						10'b0000001_010: alu_func = ALU_MULHSU;
						10'b0000001_011: alu_func = ALU_MULHU;
						default: begin   // div/rem and junk
							writes_rd = 1'b0;
							illegal   = 1'b1;
						end
					endcase
				end
				OPC_SYSTEM: begin
					// only wfi, no csrs here
					if (inst == 32'h1050_0073)
						halt = 1'b1;
					else
						illegal = 1'b1;
				end
				default: illegal = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/regfile.sv
/*
 * architectural register file
 * 2 read, 1 write, x0 hardwired, write-through on read
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

module regfile (
	input  logic                  clock,
	input  logic                  rst,
	input  logic [`REG_IDX_W-1:0] rd_idx_a,
	input  logic [`REG_IDX_W-1:0] rd_idx_b,
	output logic [`XLEN-1:0]      rd_dat_a,
	output logic [`XLEN-1:0]      rd_dat_b,
	input  logic                  wr_en,
	input  logic [`REG_IDX_W-1:0] wr_idx,
	input  logic [`XLEN-1:0]      wr_data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	// bypass covers the producer two ahead
	always_comb begin
		if (rd_idx_a == '0)                        rd_dat_a = '0;
		else if (wr_en && (wr_idx == rd_idx_a))    rd_dat_a = wr_data;
		else                                       rd_dat_a = regs[rd_idx_a];
	end

	always_comb begin
		if (rd_idx_b == '0)                        rd_dat_b = '0;
		else if (wr_en && (wr_idx == rd_idx_b))    rd_dat_b = wr_data;
		else                                       rd_dat_b = regs[rd_idx_b];
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data; // x0 never written
		end
	end

endmodule

`default_nettype wire

//--- src/id_stage.sv
/*
 * decode stage
 * decoder, register file read and the id/ex pipeline register
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

module id_stage import core_pkg::*; (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  inst_valid,
	input  logic [`XLEN-1:0]      inst,
	input  logic [`XLEN-1:0]      pc,
	input  logic                  wr_en,    // from wb
	input  logic [`REG_IDX_W-1:0] wr_idx,
	input  logic [`XLEN-1:0]      wr_data,
	id_ex_if.id                   out
);

	logic [`REG_IDX_W-1:0] rs1_idx, rs2_idx, rd_idx;
	logic [`XLEN-1:0]      rs1_val, rs2_val;
	alu_func_t             dec_alu_func;
	opa_select_t           dec_opa;
	opb_select_t           dec_opb;
	logic [`XLEN-1:0]      dec_imm;
	logic                  dec_reg_write, dec_illegal, dec_halt;

	assign rs1_idx = inst[19:15];
	assign rs2_idx = inst[24:20];
	assign rd_idx  = inst[11:7];

	decoder u_decoder (
		.inst       (inst),
		.valid_in   (inst_valid),
		.alu_func   (dec_alu_func),
		.opa_select (dec_opa),
		.opb_select (dec_opb),
		.imm        (dec_imm),
		.reg_write  (dec_reg_write),
		.illegal    (dec_illegal),
		.halt       (dec_halt)
	);

	regfile u_regfile (
		.clock    (clock),
		.rst      (rst),
		.rd_idx_a (rs1_idx),
		.rd_idx_b (rs2_idx),
		.rd_dat_a (rs1_val),
		.rd_dat_b (rs2_val),
		.wr_en    (wr_en),
		.wr_idx   (wr_idx),
		.wr_data  (wr_data)
	);

	//////////////////////////////////////////////////////////////////////
	// id/ex register, loads every cycle
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (rst) out.valid <= 1'b0;
		else     out.valid <= inst_valid;
		out.alu_func   <= dec_alu_func;
		out.opa_select <= dec_opa;
		out.opb_select <= dec_opb;
		out.pc         <= pc;
		out.imm        <= dec_imm;
		out.rs1_idx    <= rs1_idx;
		out.rs2_idx    <= rs2_idx;
		out.rs1_value  <= rs1_val;
		out.rs2_value  <= rs2_val;
		out.rd         <= rd_idx;
		out.reg_write  <= dec_reg_write; // already 0 when not valid
		out.illegal    <= dec_illegal;
		out.halt       <= dec_halt;
	end

endmodule

`default_nettype wire

//--- src/ex_stage.sv
/*
 * execute stage
 * forwarding from own result reg, operand mux, alu and multiplier
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

module ex_stage import core_pkg::*; (
	input  logic  clock,
	input  logic  rst,
	id_ex_if.ex   in,
	ex_wb_if.ex   out
);

	logic                 fwd_a, fwd_b;
	logic [`XLEN-1:0]     rs1_v, rs2_v;
	logic [`XLEN-1:0]     opa, opb;
	logic [2*`XLEN-1:0]   prod_ss, prod_su, prod_uu;
	logic [`XLEN-1:0]     result;

	// producer one ahead still sits in our output register
	assign fwd_a = out.valid & out.reg_write & (out.rd == in.rs1_idx);
	assign fwd_b = out.valid & out.reg_write & (out.rd == in.rs2_idx);
	assign rs1_v = fwd_a ? out.value : in.rs1_value;
	assign rs2_v = fwd_b ? out.value : in.rs2_value;

	always_comb begin
		case (in.opa_select)
			OPA_IS_PC:   opa = in.pc;
			OPA_IS_ZERO: opa = '0;
			default:     opa = rs1_v;
		endcase
	end

	assign opb = (in.opb_select == OPB_IS_IMM) ? in.imm : rs2_v;

	// full 64b products, pick halves below
	assign prod_ss = $signed(opa) * $signed(opb);
	assign prod_su = $signed({{`XLEN{opa[`XLEN-1]}}, opa}) * $signed({{`XLEN{1'b0}}, opb});
	assign prod_uu = {{`XLEN{1'b0}}, opa} * {{`XLEN{1'b0}}, opb};

	always_comb begin
		case (in.alu_func)
			ALU_SUB:    result = opa - opb;
			ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, opa < opb};
			ALU_AND:    result = opa & opb;
			ALU_OR:     result = opa | opb;
			ALU_XOR:    result = opa ^ opb;
			ALU_SLL:    result = opa << opb[4:0];          // shamt is low 5 bits
			ALU_SRL:    result = opa >> opb[4:0];
			ALU_SRA:    result = $signed(opa) >>> opb[4:0];
			ALU_MUL:    result = prod_uu[`XLEN-1:0];       // low half same for all
			ALU_MULH:   result = prod_ss[2*`XLEN-1:`XLEN];
			ALU_MULHSU: result = prod_su[2*`XLEN-1:`XLEN];
			ALU_MULHU:  result = prod_uu[2*`XLEN-1:`XLEN];
			default:    result = opa + opb;                // add
		endcase
	end

	// ex/wb register
	always_ff @(posedge clock) begin
		if (rst) out.valid <= 1'b0;
		else     out.valid <= in.valid;
		out.rd        <= in.rd;
		out.reg_write <= in.reg_write;
		out.value     <= result;
		out.illegal   <= in.illegal;
		out.halt      <= in.halt;
	end

endmodule

`default_nettype wire

//--- src/wb_stage.sv
/*
 * result stage
 * retires, writes the register file, counts and halts
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

module wb_stage (
	input  logic                  clock,
	input  logic                  rst,
	ex_wb_if.wb                   in,
	output logic                  wr_en,
	output logic [`REG_IDX_W-1:0] wr_idx,
	output logic [`XLEN-1:0]      wr_data,
	output logic                  retire_valid,
	output logic                  retire_we,
	output logic [`REG_IDX_W-1:0] retire_rd,
	output logic [`XLEN-1:0]      retire_data,
	output logic                  retire_illegal,
	output logic                  retire_halt,
	output logic [`XLEN-1:0]      retire_count,
	output logic                  halted
);

	logic retire_now;

	assign retire_now = in.valid & ~halted;      // dropped once halted
	assign wr_en      = retire_now & in.reg_write; // illegal/halt carry no reg_write
	assign wr_idx     = in.rd;
	assign wr_data    = in.value;

	always_ff @(posedge clock) begin
		if (rst) begin
			retire_valid   <= 1'b0;
			retire_we      <= 1'b0;
			retire_illegal <= 1'b0;
			retire_halt    <= 1'b0;
			retire_count   <= '0;
			halted         <= 1'b0;
		end else begin
			retire_valid   <= retire_now;
			retire_we      <= wr_en;
			retire_illegal <= retire_now & in.illegal;
			retire_halt    <= retire_now & in.halt;
			if (retire_now)
				retire_count <= retire_count + 1'b1; // halt counts too
			if (retire_now && in.halt)
				halted <= 1'b1;                      // sticky till rst
		end
	end

	// payload, no reset
	always_ff @(posedge clock) begin
		retire_rd   <= in.rd;
		retire_data <= in.value;
	end

endmodule

`default_nettype wire

//--- src/int_core_top.sv
/*
 * rv32 integer core top
 * decode, execute and result stages, no back-pressure
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

module int_core_top (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  inst_valid,  // one strobe per inst
	input  logic [`XLEN-1:0]      inst,
	input  logic [`XLEN-1:0]      pc,
	output logic                  retire_valid,
	output logic                  retire_we,
	output logic [`REG_IDX_W-1:0] retire_rd,
	output logic [`XLEN-1:0]      retire_data,
	output logic                  retire_illegal,
	output logic                  retire_halt,
	output logic [`XLEN-1:0]      retire_count,
	output logic                  halted
);

	// register file write path, wb back to id
	logic                  wr_en;
	logic [`REG_IDX_W-1:0] wr_idx;
	logic [`XLEN-1:0]      wr_data;

	id_ex_if id_ex ();
	ex_wb_if ex_wb ();

	id_stage u_id_stage (
		.clock      (clock),
		.rst        (rst),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_data    (wr_data),
		.out        (id_ex.id)
	);

	ex_stage u_ex_stage (
		.clock (clock),
		.rst   (rst),
		.in    (id_ex.ex),
		.out   (ex_wb.ex)
	);

	wb_stage u_wb_stage (
		.clock          (clock),
		.rst            (rst),
		.in             (ex_wb.wb),
		.wr_en          (wr_en),
		.wr_idx         (wr_idx),
		.wr_data        (wr_data),
		.retire_valid   (retire_valid),
		.retire_we      (retire_we),
		.retire_rd      (retire_rd),
		.retire_data    (retire_data),
		.retire_illegal (retire_illegal),
		.retire_halt    (retire_halt),
		.retire_count   (retire_count),
		.halted         (halted)
	);

endmodule

`default_nettype wire

//--- tb/int_core_assertions.sv
/*
 * core retire checks
 * concurrent properties on the retire ports and the halted flag
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

module int_core_assertions (
	input logic                  clock,
	input logic                  rst,
	input logic                  retire_valid,
	input logic                  retire_we,
	input logic [`REG_IDX_W-1:0] retire_rd,
	input logic                  retire_illegal,
	input logic                  retire_halt,
	input logic                  halted
);

	int error_count = 0; // failed properties so far

	////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////
	we_not_illegal_or_halt: assert property (@(posedge clock) disable iff (rst)
		retire_we |-> !(retire_illegal || retire_halt))
		else begin
			$error("register write retired with an illegal or halt word");
			error_count++;
		end

	we_rd_nonzero: assert property (@(posedge clock) disable iff (rst)
		retire_we |-> (retire_rd != '0)) // x0 never written
		else begin
			$error("register write retired to x0");
			error_count++;
		end

	////////////////////////////////////////////////////////////////////
	// halt side
	////////////////////////////////////////////////////////////////////
	halted_sticky: assert property (@(posedge clock)
		(halted && !rst) |=> halted) // only rst clears it
		else begin
			$error("halted dropped without a reset");
			error_count++;
		end

	no_retire_when_halted: assert property (@(posedge clock) disable iff (rst)
		halted |=> !retire_valid)
		else begin
			$error("instruction retired after the core halted");
			error_count++;
		end

endmodule

bind int_core_top int_core_assertions u_core_assertions (
	.clock          (clock),
	.rst            (rst),
	.retire_valid   (retire_valid),
	.retire_we      (retire_we),
	.retire_rd      (retire_rd),
	.retire_illegal (retire_illegal),
	.retire_halt    (retire_halt),
	.halted         (halted)
);

`default_nettype wire

//--- tb/int_core_tb.sv
/*
 * int core testbench
 * random rv32 stream over x0..x7, reference model, in-order retire compare
 */
`timescale 1ns/1ps
`include "core_settings.svh"
`default_nettype none

module int_core_tb;

	localparam int NUM_RANDOM  = 300;          // words before the wfi
	localparam int NUM_AFTER   = 12;           // dropped behind the halt
	localparam int RETIRE_WAIT = 100;          // idle cycles allowed
	localparam logic [31:0] WFI_WORD = 32'h1050_0073;

	// one expected retirement
	typedef struct packed {
		logic                  we;
		logic [`REG_IDX_W-1:0] rd;
		logic [`XLEN-1:0]      data;
		logic                  illegal;
		logic                  halt;
		logic                  check_data; // legal alu result
	} exp_t;

	logic                  clock;
	logic                  rst;
	logic                  inst_valid;
	logic [`XLEN-1:0]      inst;
	logic [`XLEN-1:0]      pc;
	logic                  retire_valid;
	logic                  retire_we;
	logic [`REG_IDX_W-1:0] retire_rd;
	logic [`XLEN-1:0]      retire_data;
	logic                  retire_illegal;
	logic                  retire_halt;
	logic [`XLEN-1:0]      retire_count;
	logic                  halted;

	exp_t             exp_q [$];               // program order
	logic [`XLEN-1:0] model_regs [`REG_COUNT];
	logic             model_halted;
	int               exp_total;               // retirements up to the halt
	logic             stim_done;

	int_core_top DUT (
		.clock          (clock),
		.rst            (rst),
		.inst_valid     (inst_valid),
		.inst           (inst),
		.pc             (pc),
		.retire_valid   (retire_valid),
		.retire_we      (retire_we),
		.retire_rd      (retire_rd),
		.retire_data    (retire_data),
		.retire_illegal (retire_illegal),
		.retire_halt    (retire_halt),
		.retire_count   (retire_count),
		.halted         (halted)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// failure reporting
	//////////////////////////////////////////////////////////////////////
	task automatic value_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] expv);
		$display("ERR %s got %h expected %h", sig, got, expv);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	// bound retire properties
	always @(negedge clock) begin
		assert (DUT.u_core_assertions.error_count == 0)
			else abort_run("a bound retire property failed");
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus words
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] random_inst();
		logic [4:0]  rd_f;
		logic [4:0]  rs1_f;
		logic [4:0]  rs2_f;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm12;
		int          pick;
		rd_f  = 5'($urandom_range(7, 0)); // small reg set, many deps
		rs1_f = 5'($urandom_range(7, 0));
		rs2_f = 5'($urandom_range(7, 0));
		f3    = 3'($urandom_range(7, 0));
		imm12 = 12'($urandom);
		pick  = $urandom_range(99, 0);
		if (pick < 8)
			return {20'($urandom), rd_f, 7'b0110111};     // lui
		if (pick < 15)
			return {20'($urandom), rd_f, 7'b0010111};     // auipc
		if (pick < 45) begin
			if (f3 == 3'b001)
				imm12 = {7'b0, imm12[4:0]};
			else if (f3 == 3'b101)
				imm12 = {($urandom_range(1, 0) ? 7'b0100000 : 7'b0), imm12[4:0]};
			return {imm12, rs1_f, f3, rd_f, 7'b0010011};
		end
		if (pick < 70) begin
			f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1, 0)) ?
				7'b0100000 : 7'b0;                        // sub / sra
			return {f7, rs2_f, rs1_f, f3, rd_f, 7'b0110011};
		end
		if (pick < 94)
			return {7'b0000001, rs2_f, rs1_f, 1'b0, f3[1:0], rd_f, 7'b0110011};
		// unsupported words
		case ($urandom_range(2, 0))
			0:       return {7'b0000001, rs2_f, rs1_f, 1'b1, f3[1:0], rd_f, 7'b0110011};
			1:       return {imm12, rs1_f, 3'b010, rd_f, 7'b0000011}; // lw
			default: return {7'b0100000, imm12[4:0], rs1_f, 3'b001, rd_f, 7'b0010011};
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reference model, one word against model_regs
	//////////////////////////////////////////////////////////////////////
	function automatic exp_t reference_result(input logic [31:0] w, input logic [31:0] pc_v);
		exp_t        e;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [4:0]  sh;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [63:0] ua;
		logic [63:0] ub;
		logic [63:0] prod;
		longint      sa;
		longint      sb;
		e     = '0;
		opc   = w[6:0];
		f3    = w[14:12];
		f7    = w[31:25];
		e.rd  = w[11:7];
		a     = model_regs[w[19:15]];
		b     = model_regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_u = {w[31:12], 12'b0};
		if (opc == 7'b0110111) begin
			e.data = imm_u;
		end else if (opc == 7'b0010111) begin
			e.data = pc_v + imm_u;
		end else if (opc == 7'b0010011) begin
			b  = imm_i;      // reg-imm uses the same alu rules
			sh = w[24:20];
			case (f3)
				3'b000: e.data = a + b;
				3'b010: e.data = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
				3'b011: e.data = {31'b0, a < b};
				3'b100: e.data = a ^ b;
				3'b110: e.data = a | b;
				3'b111: e.data = a & b;
				3'b001: begin
					if (f7 == 7'b0) e.data = a << sh;
					else            e.illegal = 1'b1;
				end
				default: begin
					if (f7 == 7'b0)
						e.data = a >> sh;
					else if (f7 == 7'b0100000)
						e.data = (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}});
					else
						e.illegal = 1'b1;
				end
			endcase
		end else if (opc == 7'b0110011) begin
			sh = b[4:0];
			sa = $signed(a);
			sb = $signed(b);
			ua = {32'b0, a};
			ub = {32'b0, b};
			case ({f7, f3})
				10'b0000000_000: e.data = a + b;
				10'b0100000_000: e.data = a - b;
				10'b0000000_001: e.data = a << sh;
				10'b0000000_010: e.data = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
				10'b0000000_011: e.data = {31'b0, a < b};
				10'b0000000_100: e.data = a ^ b;
				10'b0000000_101: e.data = a >> sh;
				10'b0100000_101: e.data = (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}});
				10'b0000000_110: e.data = a | b;
				10'b0000000_111: e.data = a & b;
				10'b0000001_000: begin
					prod   = ua * ub;
					e.data = prod[31:0];
				end
				10'b0000001_001: begin
					prod   = sa * sb;            // signed x signed
					e.data = prod[63:32];
				end
				10'b0000001_010: begin
					prod   = sa * longint'(ub);  // signed x unsigned
					e.data = prod[63:32];
				end
				10'b0000001_011: begin
					prod   = ua * ub;
					e.data = prod[63:32];
				end
				default: e.illegal = 1'b1;
			endcase
		end else if (w == WFI_WORD) begin
			e.halt = 1'b1;
		end else begin
			e.illegal = 1'b1;
		end
		e.check_data = !e.illegal && !e.halt;
		e.we         = e.check_data && (e.rd != 5'd0);
		return e;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus, driven on the falling edge
	//////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		exp_t             e;
		logic [`XLEN-1:0] w;
		logic [`XLEN-1:0] cur_pc;
		int               gap;
		void'($urandom(32'h3b040103));
		rst          = 1'b1;
		inst_valid   = 1'b0;
		inst         = '0;
		pc           = '0;
		stim_done    = 1'b0;
		model_halted = 1'b0;
		exp_total    = 0;
		for (int i = 0; i < `REG_COUNT; i++)
			model_regs[i] = '0;
		cur_pc = $urandom & 32'hffff_fffc;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		for (int n = 0; n < NUM_RANDOM + 1 + NUM_AFTER; n++) begin
			gap = ($urandom_range(4, 0) == 0) ? $urandom_range(3, 1) : 0;
			repeat (gap) begin
				inst_valid = 1'b0; // strobe gap
				@(negedge clock);
			end
			w          = (n == NUM_RANDOM) ? WFI_WORD : random_inst();
			inst_valid = 1'b1;
			inst       = w;
			pc         = cur_pc;
			if (!model_halted) begin
				e = reference_result(w, cur_pc);
				exp_q.push_back(e);
				exp_total++;
				if (e.we)
					model_regs[e.rd] = e.data;
				if (e.halt)
					model_halted = 1'b1; // rest is dropped
			end
			cur_pc = cur_pc + 32'd4;
			@(negedge clock);
		end
		inst_valid = 1'b0;
		stim_done  = 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// compare, sampled on the falling edge
	//////////////////////////////////////////////////////////////////////
	task automatic compare_retirement(input exp_t e, input int seen);
		assert (retire_we === e.we)
			else value_mismatch("retire_we", 32'(retire_we), 32'(e.we));
		assert (retire_illegal === e.illegal)
			else value_mismatch("retire_illegal", 32'(retire_illegal), 32'(e.illegal));
		assert (retire_halt === e.halt)
			else value_mismatch("retire_halt", 32'(retire_halt), 32'(e.halt));
		if (e.we) begin
			assert (retire_rd === e.rd)
				else value_mismatch("retire_rd", 32'(retire_rd), 32'(e.rd));
		end
		if (e.check_data) begin
			assert (retire_data === e.data)
				else value_mismatch("retire_data", retire_data, e.data);
		end
		assert (retire_count === 32'(seen))
			else value_mismatch("retire_count", retire_count, 32'(seen));
		assert (halted === e.halt)       // rises with the halt retire
			else value_mismatch("halted", 32'(halted), 32'(e.halt));
	endtask

	initial begin : compare
		exp_t e;
		int   idle;
		int   seen;
		seen = 0;
		idle = 0;
		while (rst !== 1'b0) begin
			@(negedge clock);
			idle++;
			assert (idle < 20) else abort_run("reset was never released");
		end
		idle = 0;
		while (!stim_done || exp_q.size() != 0) begin
			@(negedge clock);
			if (retire_valid) begin
				assert (exp_q.size() != 0)
					else abort_run("an instruction retired that should have been dropped");
				e = exp_q.pop_front();
				seen++;
				compare_retirement(e, seen);
				idle = 0;
			end else begin
				idle++;
				assert (idle < RETIRE_WAIT) else abort_run("timed out waiting for a retirement");
			end
		end
		// in-flight words behind the halt must vanish
		repeat (20) begin
			@(negedge clock);
			assert (retire_valid === 1'b0)
				else abort_run("an instruction retired after the halt");
			assert (halted === 1'b1)
				else value_mismatch("halted", 32'(halted), 32'd1);
		end
		assert (retire_count === 32'(exp_total))
			else value_mismatch("retire_count", retire_count, 32'(exp_total));
		assert (DUT.u_core_assertions.error_count == 0)
			else abort_run("a bound retire property failed");
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/core_pkg.sv
src/id_ex_if.sv
src/ex_wb_if.sv
src/decoder.sv
src/regfile.sv
src/id_stage.sv
src/ex_stage.sv
src/wb_stage.sv
src/int_core_top.sv
tb/int_core_assertions.sv
tb/int_core_tb.sv
